//--- project.f
src/screen_pkg.sv
src/arena_pkg.sv
src/shot_if.sv
src/cannon_ctrl.sv
src/shot_ctrl.sv
src/invader_grid.sv
src/barrier_bank.sv
src/pixel_painter.sv
src/game_top.sv
test/game_checker.sv
test/tb_top.sv

//--- run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_top -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/Vtb_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Test OK$" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- src/arena_pkg.sv
`default_nettype none

package arena_pkg;

	// Invader block: three rows of eleven, rows spaced one cell apart
	localparam int                 INV_COLS    = 11;
	localparam int                 INV_ROWS    = 3;
	localparam screen_pkg::coord_t INV_X0      = 11'd128;
	localparam screen_pkg::coord_t INV_Y0      = 11'd64;
	localparam screen_pkg::coord_t INV_Y_PITCH = 11'd32;
	localparam screen_pkg::coord_t INV_H       = 11'd30;
	// Eleven cells side by side, 352 pixels
	localparam screen_pkg::coord_t INV_ROW_W = screen_pkg::coord_t'(INV_COLS * screen_pkg::CELL);

	// One bit per invader in a row, bit index is the column
	typedef logic [INV_COLS-1:0] inv_row_t;

	// Three barriers of 3 x 2 blocks each
	localparam int                 BAR_NUM     = 3;
	localparam int                 BAR_COLS    = 3;
	localparam int                 BAR_ROWS    = 2;
	localparam screen_pkg::coord_t BAR_X0      = 11'd64;
	localparam screen_pkg::coord_t BAR_X_PITCH = 11'd192;
	localparam screen_pkg::coord_t BAR_Y       = 11'd320;
	localparam screen_pkg::coord_t BAR_W = screen_pkg::coord_t'(BAR_COLS * screen_pkg::CELL);
	localparam screen_pkg::coord_t BAR_H = screen_pkg::coord_t'(BAR_ROWS * screen_pkg::CELL);

	// Block index is row * BAR_COLS + column
	typedef logic [BAR_COLS*BAR_ROWS-1:0] bar_map_t;

	// Player cannon
	localparam screen_pkg::coord_t CANNON_Y       = 11'd416;
	localparam screen_pkg::coord_t CANNON_X_RESET = 11'd320;
	localparam screen_pkg::coord_t CANNON_X_MIN   = 11'd1;
	localparam screen_pkg::coord_t CANNON_X_MAX   = 11'd608;

	// Shot launch offset from the cannon corner, rise per frame and square size
	localparam screen_pkg::coord_t SHOT_OFS_X = 11'd14;
	localparam screen_pkg::coord_t SHOT_OFS_Y = 11'd8;
	localparam screen_pkg::coord_t SHOT_STEP  = 11'd4;
	localparam screen_pkg::coord_t SHOT_SIZE  = 11'd4;

	// Sound event codes
	typedef logic [1:0] sound_t;
	localparam sound_t SND_SILENT = 2'd0;
	localparam sound_t SND_FIRE   = 2'd1;
	localparam sound_t SND_WOUND  = 2'd2;
	localparam sound_t SND_KILL   = 2'd3;

endpackage

`default_nettype wire

//--- src/barrier_bank.sv
`timescale 1ns/1ps
`default_nettype none

module barrier_bank (
	input  wire                        clk,
	input  wire                        arst_n,
	input  wire screen_pkg::coord_t    x,
	input  wire screen_pkg::coord_t    y,
	shot_if.barrier                    shot,
	output logic                       block_intact
);

	// One map per barrier, a set bit is a block still standing
	arena_pkg::bar_map_t blocks [arena_pkg::BAR_NUM];

	screen_pkg::coord_t rel_x;
	screen_pkg::coord_t rel_y;
	screen_pkg::coord_t in_bar_x;
	logic               in_bank;
	logic [1:0]         bar_idx;
	logic [2:0]         blk_idx;

	// Barriers repeat every pitch, so the offset inside one is a remainder
	assign rel_x    = x - arena_pkg::BAR_X0;
	assign rel_y    = y - arena_pkg::BAR_Y;
	assign in_bar_x = rel_x % arena_pkg::BAR_X_PITCH;

	always_comb
	begin
		in_bank = (x >= arena_pkg::BAR_X0) &&
			(rel_x / arena_pkg::BAR_X_PITCH < arena_pkg::BAR_NUM) &&
			(in_bar_x < arena_pkg::BAR_W) &&
			(y >= arena_pkg::BAR_Y) && (rel_y < arena_pkg::BAR_H);
		bar_idx = '0;
		blk_idx = '0;
		if (in_bank)
		begin
			bar_idx = 2'(rel_x / arena_pkg::BAR_X_PITCH);
			// Row-major block number inside the barrier
			blk_idx = 3'((rel_y / screen_pkg::CELL) * arena_pkg::BAR_COLS +
				in_bar_x / screen_pkg::CELL);
		end
	end

	assign block_intact = in_bank && blocks[bar_idx][blk_idx];

	// A standing block under the shot corner stops the shot
	assign shot.hit_barrier = shot.at_scan && block_intact;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int b = 0; b < arena_pkg::BAR_NUM; b++)
				blocks[b] <= '1;
		end
		else if (shot.hit_barrier)
			blocks[bar_idx][blk_idx] <= 1'b0;
	end

endmodule

`default_nettype wire

//--- src/cannon_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cannon_ctrl (
	input  wire                        clk,
	input  wire                        arst_n,
	input  wire screen_pkg::coord_t    x,
	input  wire screen_pkg::coord_t    y,
	input  wire                        btn_left,
	input  wire                        btn_right,
	output logic                       frame_tick,
	output screen_pkg::coord_t         cannon_x,
	output logic                       on_cannon
);

	// The scan origin marks the start of a new frame
	assign frame_tick = (x == '0) && (y == '0);

	// One pixel of travel per frame, pressing both buttons cancels out
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			cannon_x <= arena_pkg::CANNON_X_RESET;
		else if (frame_tick)
		begin
			if (btn_left && !btn_right && cannon_x > arena_pkg::CANNON_X_MIN)
				cannon_x <= cannon_x - 11'd1;
			else if (btn_right && !btn_left && cannon_x < arena_pkg::CANNON_X_MAX)
				cannon_x <= cannon_x + 11'd1;
		end
	end

	// Cannon is a solid cell, left and top edges included
	assign on_cannon = (x >= cannon_x) && (x < cannon_x + screen_pkg::CELL) &&
		(y >= arena_pkg::CANNON_Y) && (y < arena_pkg::CANNON_Y + screen_pkg::CELL);

endmodule

`default_nettype wire

//--- src/game_top.sv
`timescale 1ns/1ps
`default_nettype none

module game_top (
	input  wire                        clk,
	input  wire                        arst_n,
	input  wire screen_pkg::color_t    color_fg,
	input  wire screen_pkg::coord_t    x,
	input  wire screen_pkg::coord_t    y,
	input  wire                        btn_left,
	input  wire                        btn_right,
	input  wire                        btn_fire,
	output screen_pkg::color_t         rgb,
	output arena_pkg::sound_t          sound
);

	logic               frame_tick;
	screen_pkg::coord_t cannon_x;
	logic               on_cannon;
	logic               cell_alive;
	logic               cell_wounded;
	logic               block_intact;

	// Shot probe and the hit strobes coming back from the targets
	shot_if shot0 ();

	cannon_ctrl cannon0 (
		.clk        (clk),
		.arst_n     (arst_n),
		.x          (x),
		.y          (y),
		.btn_left   (btn_left),
		.btn_right  (btn_right),
		.frame_tick (frame_tick),
		.cannon_x   (cannon_x),
		.on_cannon  (on_cannon)
	);

	shot_ctrl shot_ctrl0 (
		.clk        (clk),
		.arst_n     (arst_n),
		.x          (x),
		.y          (y),
		.frame_tick (frame_tick),
		.cannon_x   (cannon_x),
		.btn_fire   (btn_fire),
		.shot       (shot0),
		.sound      (sound)
	);

	invader_grid invaders0 (
		.clk          (clk),
		.arst_n       (arst_n),
		.x            (x),
		.y            (y),
		.shot         (shot0),
		.cell_alive   (cell_alive),
		.cell_wounded (cell_wounded)
	);

	barrier_bank barriers0 (
		.clk          (clk),
		.arst_n       (arst_n),
		.x            (x),
		.y            (y),
		.shot         (shot0),
		.block_intact (block_intact)
	);

	pixel_painter painter0 (
		.clk          (clk),
		.arst_n       (arst_n),
		.x            (x),
		.y            (y),
		.color_fg     (color_fg),
		.on_cannon    (on_cannon),
		.cell_alive   (cell_alive),
		.cell_wounded (cell_wounded),
		.block_intact (block_intact),
		.shot         (shot0),
		.rgb          (rgb)
	);

endmodule

`default_nettype wire

//--- src/invader_grid.sv
`timescale 1ns/1ps
`default_nettype none

module invader_grid (
	input  wire                        clk,
	input  wire                        arst_n,
	input  wire screen_pkg::coord_t    x,
	input  wire screen_pkg::coord_t    y,
	shot_if.invader                    shot,
	output logic                       cell_alive,
	output logic                       cell_wounded
);

	// A set alive bit means the invader is still drawn
	arena_pkg::inv_row_t alive [arena_pkg::INV_ROWS];
	// A set wound bit means the invader has taken its first hit
	arena_pkg::inv_row_t wounded [arena_pkg::INV_ROWS];

	screen_pkg::coord_t rel_x;
	screen_pkg::coord_t rel_y;
	logic               in_grid;
	logic [1:0]         row_idx;
	logic [3:0]         col_idx;

	// Offsets from the grid corner, wrap below the corner is caught by in_grid
	assign rel_x = x - arena_pkg::INV_X0;
	assign rel_y = y - arena_pkg::INV_Y0;

	always_comb
	begin
		// The last two lines of each row pitch are a gap between rows
		in_grid = (x >= arena_pkg::INV_X0) && (rel_x < arena_pkg::INV_ROW_W) &&
			(y >= arena_pkg::INV_Y0) && (rel_y / arena_pkg::INV_Y_PITCH < arena_pkg::INV_ROWS) &&
			(rel_y % arena_pkg::INV_Y_PITCH < arena_pkg::INV_H);
		row_idx = '0;
		col_idx = '0;
		// Indices stay in range outside the grid
		if (in_grid)
		begin
			row_idx = 2'(rel_y / arena_pkg::INV_Y_PITCH);
			col_idx = 4'(rel_x / screen_pkg::CELL);
		end
	end

	assign cell_alive   = in_grid && alive[row_idx][col_idx];
	assign cell_wounded = in_grid && wounded[row_idx][col_idx];

	// The shot corner on a live invader is a hit, a second hit kills it
	assign shot.hit_invader = shot.at_scan && cell_alive;
	assign shot.kill        = shot.hit_invader && cell_wounded;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int r = 0; r < arena_pkg::INV_ROWS; r++)
			begin
				alive[r]   <= '1;
				wounded[r] <= '0;
			end
		end
		else if (shot.hit_invader)
		begin
			// The wound bit of a dead invader is left set, alive masks it
			if (cell_wounded)
				alive[row_idx][col_idx] <= 1'b0;
			else
				wounded[row_idx][col_idx] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- src/pixel_painter.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_painter (
	input  wire                        clk,
	input  wire                        arst_n,
	input  wire screen_pkg::coord_t    x,
	input  wire screen_pkg::coord_t    y,
	input  wire screen_pkg::color_t    color_fg,
	input  wire                        on_cannon,
	input  wire                        cell_alive,
	input  wire                        cell_wounded,
	input  wire                        block_intact,
	shot_if.painter                    shot,
	output screen_pkg::color_t         rgb
);

	screen_pkg::color_t color_next;

	// Layers are applied back to front, each one overwrites the last
	always_comb
	begin
		if (x >= screen_pkg::SCREEN_W || y >= screen_pkg::SCREEN_H)
		begin
			// Blanking region
			color_next = screen_pkg::COLOR_NULL;
		end
		else
		begin
			color_next = screen_pkg::COLOR_BACKGROUND;

			if (block_intact)
				color_next = color_fg;

			// Wounded invaders keep their shape but change colour
			if (cell_alive)
				color_next = cell_wounded ? screen_pkg::COLOR_WOUNDED : color_fg;

			if (on_cannon)
				color_next = color_fg;

			// Shot is on top of everything
			if (shot.on_pixel)
				color_next = color_fg;
		end
	end

	// One cycle of latency from scan point to colour
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			rgb <= screen_pkg::COLOR_NULL;
		else
			rgb <= color_next;
	end

endmodule

`default_nettype wire

//--- src/screen_pkg.sv
`default_nettype none

package screen_pkg;

	// Scan coordinates arrive as 11-bit unsigned values
	typedef logic [10:0] coord_t;

	// One byte of colour per pixel
	typedef logic [7:0] color_t;

	// Visible area of the display
	localparam coord_t SCREEN_W = 11'd640;
	localparam coord_t SCREEN_H = 11'd480;

	// Fixed palette entries; the foreground colour comes in from outside
	localparam color_t COLOR_BACKGROUND = 8'h48;
	localparam color_t COLOR_WOUNDED    = 8'h3C;
	localparam color_t COLOR_NULL       = 8'h00;

	// Every object on the screen is built from square cells of this size
	localparam coord_t CELL = 11'd32;

endpackage

`default_nettype wire

//--- src/shot_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module shot_ctrl (
	input  wire                        clk,
	input  wire                        arst_n,
	input  wire screen_pkg::coord_t    x,
	input  wire screen_pkg::coord_t    y,
	input  wire                        frame_tick,
	input  wire screen_pkg::coord_t    cannon_x,
	input  wire                        btn_fire,
	shot_if.shooter                    shot,
	output arena_pkg::sound_t          sound
);

	logic               active;
	screen_pkg::coord_t shot_x;
	screen_pkg::coord_t shot_y;

	// Only the top-left corner of the shot probes for collisions
	assign shot.at_scan = active && (x == shot_x) && (y == shot_y);

	assign shot.on_pixel = active &&
		(x >= shot_x) && (x < shot_x + arena_pkg::SHOT_SIZE) &&
		(y >= shot_y) && (y < shot_y + arena_pkg::SHOT_SIZE);

	// Control state and the sound register
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			active <= 1'b0;
			sound  <= arena_pkg::SND_SILENT;
		end
		else if (shot.hit_invader || shot.hit_barrier)
		begin
			// Any hit ends the shot, only invader hits make a sound
			active <= 1'b0;
			if (shot.hit_invader)
				sound <= shot.kill ? arena_pkg::SND_KILL : arena_pkg::SND_WOUND;
		end
		else if (frame_tick)
		begin
			if (active)
			begin
				// Leaves through the top once a full step no longer fits
				if (shot_y < arena_pkg::SHOT_STEP)
					active <= 1'b0;
			end
			else if (btn_fire)
			begin
				active <= 1'b1;
				sound  <= arena_pkg::SND_FIRE;
			end
		end
	end

	// Position follows the same frame rules, meaningless while inactive
	always_ff @(posedge clk)
	begin
		if (frame_tick)
		begin
			if (!active && btn_fire)
			begin
				shot_x <= cannon_x + arena_pkg::SHOT_OFS_X;
				shot_y <= arena_pkg::CANNON_Y - arena_pkg::SHOT_OFS_Y;
			end
			else if (active && shot_y >= arena_pkg::SHOT_STEP)
				shot_y <= shot_y - arena_pkg::SHOT_STEP;
		end
	end

endmodule

`default_nettype wire

//--- src/shot_if.sv
`timescale 1ns/1ps
`default_nettype none

interface shot_if;

	// Shot sits exactly on the current scan point
	logic at_scan;
	// Scan point falls inside the shot square
	logic on_pixel;
	// Hit strobes, valid in the at_scan cycle
	logic hit_invader;
	logic kill;
	logic hit_barrier;

	modport shooter (output at_scan, output on_pixel, input hit_invader, input kill,
		input hit_barrier);
	modport invader (input at_scan, output hit_invader, output kill);
	modport barrier (input at_scan, output hit_barrier);
	modport painter (input on_pixel);

endinterface

`default_nettype wire

//--- test/game_checker.sv
`timescale 1ns/1ps
`default_nettype none

module game_checker (
	input  wire                     clk,
	input  wire                     arst_n,
	input  wire screen_pkg::color_t color_fg,
	input  wire screen_pkg::coord_t x,
	input  wire screen_pkg::coord_t y,
	input  wire                     btn_left,
	input  wire                     btn_right,
	input  wire                     btn_fire,
	input  wire screen_pkg::color_t rgb,
	input  wire arena_pkg::sound_t  sound,
	output int                      rgb_errors,
	output int                      sound_errors,
	output int                      compares
);

	// Screen layout as plain integers for the model
	localparam int CELL  = int'(screen_pkg::CELL);
	localparam int INV_X = int'(arena_pkg::INV_X0);
	localparam int INV_Y = int'(arena_pkg::INV_Y0);
	localparam int BAR_X = int'(arena_pkg::BAR_X0);
	localparam int BAR_P = int'(arena_pkg::BAR_X_PITCH);
	localparam int BAR_Y = int'(arena_pkg::BAR_Y);
	localparam int CAN_Y = int'(arena_pkg::CANNON_Y);

	// Model of the game state
	int                cannon_x;
	bit                shot_on;
	int                shot_x;
	int                shot_y;
	bit                inv_alive [3][11];
	bit                inv_wound [3][11];
	bit                bar_blk [3][6];
	arena_pkg::sound_t snd;

	// What the DUT must show after the last rising edge
	screen_pkg::color_t exp_rgb;
	arena_pkg::sound_t  exp_snd;
	int                 exp_x;
	int                 exp_y;
	bit                 armed = 1'b0;
	int                 rgb_err_cnt = 0;
	int                 snd_err_cnt = 0;
	int                 cmp_cnt = 0;

	assign rgb_errors   = rgb_err_cnt;
	assign sound_errors = snd_err_cnt;
	assign compares     = cmp_cnt;

	// Invader cell under a point
	// The last two lines of each 32 line row are empty
	function automatic bit invader_at(input int px, input int py, output int r, output int c);
		r = 0;
		c = 0;
		if (px < INV_X || px >= INV_X + 11 * CELL || py < INV_Y || py >= INV_Y + 3 * CELL)
			return 1'b0;
		if ((py - INV_Y) % CELL >= int'(arena_pkg::INV_H))
			return 1'b0;
		r = (py - INV_Y) / CELL;
		c = (px - INV_X) / CELL;
		return 1'b1;
	endfunction

	// Barrier and block under a point
	// Blocks are numbered row by row
	function automatic bit block_at(input int px, input int py, output int b, output int k);
		b = 0;
		k = 0;
		if (px < BAR_X || py < BAR_Y || py >= BAR_Y + 2 * CELL)
			return 1'b0;
		if ((px - BAR_X) / BAR_P > 2 || (px - BAR_X) % BAR_P >= 3 * CELL)
			return 1'b0;
		b = (px - BAR_X) / BAR_P;
		k = ((py - BAR_Y) / CELL) * 3 + ((px - BAR_X) % BAR_P) / CELL;
		return 1'b1;
	endfunction

	// Expected colour of one point
	// Layers are painted back to front
	function automatic screen_pkg::color_t ref_color(input int px, input int py,
		input screen_pkg::color_t fg);
		int                 r;
		int                 c;
		int                 b;
		int                 k;
		bit                 in_inv;
		bit                 in_bar;
		screen_pkg::color_t col;
		if (px >= 640 || py >= 480)
			return screen_pkg::COLOR_NULL;
		in_inv = invader_at(px, py, r, c);
		in_bar = block_at(px, py, b, k);
		col = screen_pkg::COLOR_BACKGROUND;
		if (in_bar && bar_blk[b][k])
			col = fg;
		if (in_inv && inv_alive[r][c])
			col = inv_wound[r][c] ? screen_pkg::COLOR_WOUNDED : fg;
		if (px >= cannon_x && px < cannon_x + CELL && py >= CAN_Y && py < CAN_Y + CELL)
			col = fg;
		if (shot_on && px >= shot_x && px < shot_x + 4 && py >= shot_y && py < shot_y + 4)
			col = fg;
		return col;
	endfunction

	task automatic model_reset();
		cannon_x = int'(arena_pkg::CANNON_X_RESET);
		shot_on  = 1'b0;
		shot_x   = 0;
		shot_y   = 0;
		snd      = arena_pkg::SND_SILENT;
		for (int r = 0; r < 3; r++)
		begin
			for (int c = 0; c < 11; c++)
			begin
				inv_alive[r][c] = 1'b1;
				inv_wound[r][c] = 1'b0;
			end
		end
		for (int b = 0; b < 3; b++)
		begin
			for (int k = 0; k < 6; k++)
				bar_blk[b][k] = 1'b1;
		end
	endtask

	// Inputs are stable at the rising edge, so the model steps here
	always @(posedge clk)
	begin
		int px;
		int py;
		int r;
		int c;
		int b;
		int k;
		bit tick;
		bit at_scan;
		bit hit_inv;
		bit hit_bar;
		px = int'(x);
		py = int'(y);
		exp_x = px;
		exp_y = py;
		armed = 1'b1;
		if (!arst_n)
		begin
			model_reset();
			exp_rgb = screen_pkg::COLOR_NULL;
		end
		else
		begin
			// Colour comes from the state before this edge
			exp_rgb = ref_color(px, py, color_fg);
			tick    = (px == 0) && (py == 0);
			at_scan = shot_on && (px == shot_x) && (py == shot_y);
			hit_inv = invader_at(px, py, r, c) && at_scan && inv_alive[r][c];
			hit_bar = block_at(px, py, b, k) && at_scan && bar_blk[b][k];
			if (hit_inv || hit_bar)
			begin
				shot_on = 1'b0;
				if (hit_inv && inv_wound[r][c])
				begin
					inv_alive[r][c] = 1'b0;
					snd = arena_pkg::SND_KILL;
				end
				else if (hit_inv)
				begin
					inv_wound[r][c] = 1'b1;
					snd = arena_pkg::SND_WOUND;
				end
				else
					bar_blk[b][k] = 1'b0;
			end
			else if (tick && shot_on)
			begin
				if (shot_y < 4)
					shot_on = 1'b0;
				else
					shot_y = shot_y - 4;
			end
			else if (tick && btn_fire)
			begin
				// Launch uses the cannon position from before its move
				shot_on = 1'b1;
				shot_x  = cannon_x + 14;
				shot_y  = CAN_Y - 8;
				snd     = arena_pkg::SND_FIRE;
			end
			if (tick && btn_left && !btn_right && cannon_x > 1)
				cannon_x = cannon_x - 1;
			else if (tick && btn_right && !btn_left && cannon_x < 608)
				cannon_x = cannon_x + 1;
		end
		exp_snd = snd;
	end

	// Outputs only move at the rising edge and have settled by the falling edge
	always @(negedge clk)
	begin
		if (armed)
		begin
			cmp_cnt++;
			if (rgb !== exp_rgb)
			begin
				rgb_err_cnt++;
				$display("Mismatch at %0d ns: rgb for (%0d,%0d) expected %h, actual %h",
					$time, exp_x, exp_y, exp_rgb, rgb);
			end
			if (sound !== exp_snd)
			begin
				snd_err_cnt++;
				$display("Mismatch at %0d ns: sound expected %0d, actual %0d",
					$time, exp_snd, sound);
			end
		end
	end

endmodule

`default_nettype wire

//--- test/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

	// The stimulus below takes at most this many clock cycles
	// Each step takes one clock cycle
	localparam int NUM_STEPS   = 2100;
	localparam int WATCHDOG_NS = (NUM_STEPS + 10) * 4 * 2;
	localparam screen_pkg::color_t FG = 8'hE3;
	// Launch column with the cannon at its reset position is 320 + 14
	localparam int SHOT_X = 334;

	logic               clk;
	logic               arst_n;
	screen_pkg::color_t color_fg;
	screen_pkg::coord_t x;
	screen_pkg::coord_t y;
	logic               btn_left;
	logic               btn_right;
	logic               btn_fire;
	screen_pkg::color_t rgb;
	arena_pkg::sound_t  sound;

	int     rgb_errors;
	int     sound_errors;
	int     compares;
	int     probe_errors = 0;
	int     shot_y = 0;
	integer seed = 32'hd089_f7e1;

	game_top dut0 (
		.clk       (clk),
		.arst_n    (arst_n),
		.color_fg  (color_fg),
		.x         (x),
		.y         (y),
		.btn_left  (btn_left),
		.btn_right (btn_right),
		.btn_fire  (btn_fire),
		.rgb       (rgb),
		.sound     (sound)
	);

	game_checker chk0 (
		.clk          (clk),
		.arst_n       (arst_n),
		.color_fg     (color_fg),
		.x            (x),
		.y            (y),
		.btn_left     (btn_left),
		.btn_right    (btn_right),
		.btn_fire     (btn_fire),
		.rgb          (rgb),
		.sound        (sound),
		.rgb_errors   (rgb_errors),
		.sound_errors (sound_errors),
		.compares     (compares)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Called at a falling edge and holds the point for exactly one clock
	task automatic step(input int px, input int py, input bit l, input bit r, input bit f);
		x         = screen_pkg::coord_t'(px);
		y         = screen_pkg::coord_t'(py);
		btn_left  = l;
		btn_right = r;
		btn_fire  = f;
		@(negedge clk);
	endtask

	// The scan origin counts as one frame
	task automatic frames(input int n, input bit l, input bit r, input bit f);
		repeat (n) step(0, 0, l, r, f);
	endtask

	task automatic probe(input int px, input int py, input screen_pkg::color_t expected);
		step(px, py, 1'b0, 1'b0, 1'b0);
		if (rgb !== expected)
		begin
			probe_errors++;
			$display("Mismatch at %0d ns: rgb at (%0d,%0d) expected %h, actual %h",
				$time, px, py, expected, rgb);
		end
	endtask

	task automatic expect_sound(input arena_pkg::sound_t expected);
		if (sound !== expected)
		begin
			probe_errors++;
			$display("Mismatch at %0d ns: sound expected %0d, actual %0d",
				$time, expected, sound);
		end
	endtask

	// Corner pixels of the 32 x 32 cannon and the pixels just outside
	task automatic check_cannon(input int cx);
		probe(cx, 416, FG);
		probe(cx - 1, 416, screen_pkg::COLOR_BACKGROUND);
		probe(cx + 31, 447, FG);
		probe(cx + 32, 447, (cx + 32 >= 640) ? screen_pkg::COLOR_NULL :
			screen_pkg::COLOR_BACKGROUND);
	endtask

	task automatic fire();
		frames(1, 1'b0, 1'b0, 1'b1);
		shot_y = 408;
		expect_sound(arena_pkg::SND_FIRE);
	endtask

	// Frames until the shot corner reaches the given line
	task automatic rise_to(input int ty);
		while (shot_y > ty)
		begin
			frames(1, 1'b0, 1'b0, 1'b0);
			shot_y = shot_y - 4;
		end
	endtask

	// Points spread a little past the visible area to reach the blanking region
	task automatic random_probes(input int n);
		int rx;
		int ry;
		repeat (n)
		begin
			rx = {$random(seed)} % 704;
			ry = {$random(seed)} % 544;
			step(rx, ry, 1'b0, 1'b0, 1'b0);
		end
	endtask

	initial
	begin
		int total;
		arst_n    = 1'b0;
		color_fg  = FG;
		x         = 11'd700;
		y         = 11'd500;
		btn_left  = 1'b0;
		btn_right = 1'b0;
		btn_fire  = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		// Picture right after reset
		probe(130, 66, FG);
		probe(470, 150, FG);
		probe(140, 95, screen_pkg::COLOR_BACKGROUND);
		probe(70, 330, FG);
		probe(330, 420, FG);
		probe(10, 10, screen_pkg::COLOR_BACKGROUND);
		probe(650, 10, screen_pkg::COLOR_NULL);
		probe(10, 500, screen_pkg::COLOR_NULL);
		expect_sound(arena_pkg::SND_SILENT);
		random_probes(100);

		// Cannon steps, both buttons, and both end stops
		frames(5, 1'b1, 1'b0, 1'b0);
		check_cannon(315);
		frames(3, 1'b0, 1'b1, 1'b0);
		check_cannon(318);
		frames(4, 1'b1, 1'b1, 1'b0);
		check_cannon(318);
		frames(330, 1'b1, 1'b0, 1'b0);
		check_cannon(1);
		frames(620, 1'b0, 1'b1, 1'b0);
		check_cannon(608);
		frames(288, 1'b1, 1'b0, 1'b0);
		check_cannon(320);
		random_probes(100);

		// Launch, rise, a second fire in flight, exit at the top
		fire();
		probe(335, 409, FG);
		rise_to(404);
		probe(335, 409, screen_pkg::COLOR_BACKGROUND);
		probe(335, 405, FG);
		frames(1, 1'b0, 1'b0, 1'b1);
		shot_y = 400;
		probe(335, 409, screen_pkg::COLOR_BACKGROUND);
		probe(335, 401, FG);
		expect_sound(arena_pkg::SND_FIRE);
		rise_to(0);
		probe(335, 1, FG);
		frames(1, 1'b0, 1'b0, 1'b0);
		probe(335, 1, screen_pkg::COLOR_BACKGROUND);

		// Two hits on the bottom invader of column 6, then a shot through its cell
		fire();
		rise_to(156);
		step(SHOT_X, 156, 1'b0, 1'b0, 1'b0);
		expect_sound(arena_pkg::SND_WOUND);
		probe(330, 140, screen_pkg::COLOR_WOUNDED);
		fire();
		rise_to(156);
		step(SHOT_X, 156, 1'b0, 1'b0, 1'b0);
		expect_sound(arena_pkg::SND_KILL);
		probe(330, 140, screen_pkg::COLOR_BACKGROUND);
		fire();
		rise_to(156);
		step(SHOT_X, 156, 1'b0, 1'b0, 1'b0);
		probe(335, 157, FG);
		rise_to(124);
		step(SHOT_X, 124, 1'b0, 1'b0, 1'b0);
		expect_sound(arena_pkg::SND_WOUND);
		probe(330, 110, screen_pkg::COLOR_WOUNDED);

		// Lower right block of the middle barrier
		fire();
		rise_to(352);
		step(SHOT_X, 352, 1'b0, 1'b0, 1'b0);
		expect_sound(arena_pkg::SND_FIRE);
		probe(340, 360, screen_pkg::COLOR_BACKGROUND);
		probe(300, 360, FG);
		probe(340, 330, FG);
		// A shot still in flight would take the block above at this point
		frames(1, 1'b0, 1'b0, 1'b0);
		step(SHOT_X, 348, 1'b0, 1'b0, 1'b0);
		probe(340, 330, FG);
		random_probes(200);

		total = rgb_errors + sound_errors + probe_errors;
		$display("Errors: %0d rgb, %0d sound, %0d probe over %0d compares",
			rgb_errors, sound_errors, probe_errors, compares);
		if (total == 0 && compares > 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns before the stimulus finished", WATCHDOG_NS);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire
